/* hw/gemm_pkg.sv */
/*
 * shared widths for the gemm accelerator
 * memory channel structs for read request, read response and write request
 * result array type handed from the MM engine to the DMA engine
 */

package gemm_pkg;

    // signed operand element
    parameter int ELEM_W   = 8;
    // edge of the multiply array
    parameter int SA_WIDTH = 4;
    // one memory beat carries one column of A or one row of B
    parameter int BEAT_W   = SA_WIDTH * ELEM_W;
    // accumulator and C word
    parameter int ACC_W    = 32;
    // byte address
    parameter int ADDR_W   = 32;
    // buffer index field of the read id
    // the DMA engine uses the low BUF_AW bits
    parameter int RD_IDX_W = 6;

    // read id, echoed back by memory
    typedef struct packed {
        logic                sel;
        logic [RD_IDX_W-1:0] idx;
    } rd_id_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        rd_id_t            id;
    } mem_rd_req_t;

    typedef struct packed {
        logic [BEAT_W-1:0] data;
        rd_id_t            id;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ACC_W-1:0]  data;
    } mem_wr_req_t;

    // [row][col] of signed sums
    typedef logic signed [SA_WIDTH-1:0][SA_WIDTH-1:0][ACC_W-1:0] acc_array_t;

endpackage

/* hw/tile_buffer.sv */
/*
 * tile_buffer: one write port, one read port
 * read data registered, one cycle after the index
 */

`timescale 1ns/1ns

module tile_buffer #(
    parameter int BUF_AW = 6
) (
    input  logic                        clk,
    input  logic                        we_i,
    input  logic [BUF_AW-1:0]           waddr_i,
    input  logic [gemm_pkg::BEAT_W-1:0] wdata_i,
    input  logic [BUF_AW-1:0]           raddr_i,
    output logic [gemm_pkg::BEAT_W-1:0] rdata_o
);
    import gemm_pkg::*;

    // one beat per k index
    logic [BEAT_W-1:0] mem [2**BUF_AW];

    // write side, filled by the DMA engine during the read phase
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read side, walked by the MM engine
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* hw/dma_engine.sv */
/*
 * dma_engine: control FSM of the accelerator
 * interleaved A/B read requests, response steering into the tile buffers,
 * MM start/done handshake and write-back of the 16 results of C
 */

`timescale 1ns/1ns

module dma_engine #(
    parameter int BUF_AW = 6
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // configuration and status
    input  logic [gemm_pkg::ADDR_W-1:0]   mat_a_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0]   mat_b_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0]   mat_c_addr_i,
    input  logic [BUF_AW:0]               mat_k_i,
    input  logic                          start_i,
    output logic                          done_o,
    output logic                          busy_o,
    // memory channels
    output gemm_pkg::mem_rd_req_t         rd_req_o,
    output logic                          rd_req_valid_o,
    input  logic                          rd_req_ready_i,
    input  gemm_pkg::mem_rd_rsp_t         rd_rsp_i,
    input  logic                          rd_rsp_valid_i,
    output logic                          rd_rsp_ready_o,
    output gemm_pkg::mem_wr_req_t         wr_req_o,
    output logic                          wr_req_valid_o,
    input  logic                          wr_req_ready_i,
    // tile buffer write ports
    output logic                          buf_a_we_o,
    output logic                          buf_b_we_o,
    output logic [BUF_AW-1:0]             buf_widx_o,
    output logic [gemm_pkg::BEAT_W-1:0]   buf_wdata_o,
    // MM engine handshake
    output logic                          mm_start_o,
    output logic [BUF_AW:0]               mm_k_o,
    input  logic                          mm_done_i,
    input  gemm_pkg::acc_array_t          acc_i
);
    import gemm_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT_MM,
        WRITE_C
    } state_t;

    state_t state_q;

    // job registers, taken at start
    logic [ADDR_W-1:0] a_base_q;
    logic [ADDR_W-1:0] b_base_q;
    logic [ADDR_W-1:0] c_base_q;
    logic [BUF_AW:0]   k_q;

    // request side: beat index, A/B select, all issued
    logic [BUF_AW-1:0] req_idx_q;
    logic              req_sel_q;
    logic              req_done_q;
    // responses seen, up to 2K
    logic [BUF_AW+1:0] rsp_cnt_q;
    // result walk, row in [3:2], col in [1:0]
    logic [3:0]        wr_cnt_q;

    logic              start_ok;
    logic              rd_fire;
    logic              rsp_fire;
    logic              rsp_last;
    logic              wr_fire;
    logic [ADDR_W-1:0] req_base;

    // K of zero never leaves IDLE
    assign start_ok = (state_q == IDLE) && start_i && (mat_k_i != '0);
    assign rd_fire  = rd_req_valid_o && rd_req_ready_i;
    assign rsp_fire = rd_rsp_valid_i && rd_rsp_ready_o && (state_q == READ);
    assign rsp_last = rsp_fire && (rsp_cnt_q == {k_q, 1'b0} - 1'b1);
    assign wr_fire  = wr_req_valid_o && wr_req_ready_i;

    // responses are never back-pressured
    assign rd_rsp_ready_o = 1'b1;
    assign busy_o         = (state_q != IDLE);
    assign mm_k_o         = k_q;

    // read request built from the counters
    // counters only move on a transfer, so the struct holds under stalls
    assign rd_req_valid_o = (state_q == READ) && !req_done_q;
    assign req_base       = req_sel_q ? b_base_q : a_base_q;

    always_comb begin
        // beat k sits 4 bytes past beat k-1
        rd_req_o.addr   = req_base + (ADDR_W'(req_idx_q) << 2);
        rd_req_o.id.sel = req_sel_q;
        rd_req_o.id.idx = RD_IDX_W'(req_idx_q);
    end

    // C write-back in row-major order
    assign wr_req_valid_o = (state_q == WRITE_C);

    always_comb begin
        wr_req_o.addr = c_base_q + (ADDR_W'(wr_cnt_q) << 2);
        wr_req_o.data = acc_i[wr_cnt_q[3:2]][wr_cnt_q[1:0]];
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
            k_q      <= mat_k_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            req_idx_q  <= '0;
            req_sel_q  <= 1'b0;
            req_done_q <= 1'b0;
            rsp_cnt_q  <= '0;
            wr_cnt_q   <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            // single-cycle pulses
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_ok) begin
                        state_q    <= READ;
                        req_idx_q  <= '0;
                        req_sel_q  <= 1'b0;
                        req_done_q <= 1'b0;
                        rsp_cnt_q  <= '0;
                    end
                end
                READ: begin
                    // A column k, then B row k, then k+1
                    if (rd_fire) begin
                        if (req_sel_q) begin
                            req_sel_q <= 1'b0;
                            if ({1'b0, req_idx_q} == k_q - 1'b1) begin
                                req_done_q <= 1'b1;
                            end else begin
                                req_idx_q <= req_idx_q + 1'b1;
                            end
                        end else begin
                            req_sel_q <= 1'b1;
                        end
                    end
                    if (rsp_fire) begin
                        rsp_cnt_q <= rsp_cnt_q + 1'b1;
                    end
                    // last beat lands in its buffer before the MM engine reads
                    if (rsp_last) begin
                        state_q    <= WAIT_MM;
                        mm_start_o <= 1'b1;
                    end
                end
                WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q  <= WRITE_C;
                        wr_cnt_q <= '0;
                    end
                end
                WRITE_C: begin
                    if (wr_fire) begin
                        if (wr_cnt_q == 4'hf) begin
                            state_q <= IDLE;
                            done_o  <= 1'b1;
                        end else begin
                            wr_cnt_q <= wr_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // response steering, id bit picks the buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_we_o <= 1'b0;
            buf_b_we_o <= 1'b0;
        end else begin
            buf_a_we_o <= rsp_fire && !rd_rsp_i.id.sel;
            buf_b_we_o <= rsp_fire && rd_rsp_i.id.sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            buf_widx_o  <= rd_rsp_i.id.idx[BUF_AW-1:0];
            buf_wdata_o <= rd_rsp_i.data;
        end
    end

endmodule

/* hw/mm_engine.sv */
/*
 * mm_engine: 4x4 multiply-accumulate array
 * streams K beat pairs from the tile buffers, adds one outer product per beat
 */

`timescale 1ns/1ns

module mm_engine #(
    parameter int BUF_AW = 6
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic [BUF_AW:0]             k_i,
    output logic                        done_o,
    output logic [BUF_AW-1:0]           raddr_o,
    input  logic [gemm_pkg::BEAT_W-1:0] a_col_i,
    input  logic [gemm_pkg::BEAT_W-1:0] b_row_i,
    output gemm_pkg::acc_array_t        acc_o
);
    import gemm_pkg::*;

    logic [BUF_AW:0]          k_q;
    // read stage
    logic [BUF_AW-1:0]        rd_idx_q;
    logic                     rd_vld_q;
    logic                     rd_last;
    // data stage, one cycle behind for the buffer latency
    logic                     dat_vld_q;
    logic                     dat_last_q;
    logic                     done_q;
    acc_array_t               acc_q;

    // element i of A column k, element j of B row k
    logic signed [ELEM_W-1:0] a_el [SA_WIDTH];
    logic signed [ELEM_W-1:0] b_el [SA_WIDTH];

    assign rd_last = rd_vld_q && ({1'b0, rd_idx_q} == k_q - 1'b1);
    assign raddr_o = rd_idx_q;
    assign done_o  = done_q;
    assign acc_o   = acc_q;

    always_comb begin
        for (int e = 0; e < SA_WIDTH; e++) begin
            a_el[e] = a_col_i[e*ELEM_W +: ELEM_W];
            b_el[e] = b_row_i[e*ELEM_W +: ELEM_W];
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            k_q <= k_i;
        end
    end

    // index walk 0..K-1, then the valid bit runs down the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx_q   <= '0;
            rd_vld_q   <= 1'b0;
            dat_vld_q  <= 1'b0;
            dat_last_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            dat_vld_q  <= rd_vld_q;
            dat_last_q <= rd_last;
            // high once the last product is in
            done_q     <= dat_last_q;
            if (start_i) begin
                rd_vld_q <= 1'b1;
                rd_idx_q <= '0;
            end else if (rd_last) begin
                rd_vld_q <= 1'b0;
            end else if (rd_vld_q) begin
                rd_idx_q <= rd_idx_q + 1'b1;
            end
        end
    end

    // outer product per beat pair
    // sums stay put after done until the next start
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q <= '0;
        end else if (dat_vld_q) begin
            for (int i = 0; i < SA_WIDTH; i++) begin
                for (int j = 0; j < SA_WIDTH; j++) begin
                    // elements sign-extended to the sum width before the multiply
                    acc_q[i][j] <= $signed(acc_q[i][j]) + ACC_W'(a_el[i]) * ACC_W'(b_el[j]);
                end
            end
        end
    end

endmodule

/* hw/gemm_top.sv */
/*
 * gemm_top: DMA engine, A and B tile buffers, MM engine
 */

`timescale 1ns/1ns

module gemm_top #(
    parameter int BUF_AW = 6
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [gemm_pkg::ADDR_W-1:0] mat_a_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0] mat_b_addr_i,
    input  logic [gemm_pkg::ADDR_W-1:0] mat_c_addr_i,
    input  logic [BUF_AW:0]             mat_k_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic                        busy_o,
    output gemm_pkg::mem_rd_req_t       rd_req_o,
    output logic                        rd_req_valid_o,
    input  logic                        rd_req_ready_i,
    input  gemm_pkg::mem_rd_rsp_t       rd_rsp_i,
    input  logic                        rd_rsp_valid_i,
    output logic                        rd_rsp_ready_o,
    output gemm_pkg::mem_wr_req_t       wr_req_o,
    output logic                        wr_req_valid_o,
    input  logic                        wr_req_ready_i
);
    import gemm_pkg::*;

    // shared buffer write port, one enable per buffer
    logic              buf_a_we;
    logic              buf_b_we;
    logic [BUF_AW-1:0] buf_widx;
    logic [BEAT_W-1:0] buf_wdata;
    // MM engine side
    logic [BUF_AW-1:0] mm_raddr;
    logic [BEAT_W-1:0] a_col;
    logic [BEAT_W-1:0] b_row;
    logic              mm_start;
    logic [BUF_AW:0]   mm_k;
    logic              mm_done;
    acc_array_t        acc;

    dma_engine #(.BUF_AW(BUF_AW)) u_dma (
        .clk            (clk),
        .rst_n          (rst_n),
        .mat_a_addr_i   (mat_a_addr_i),
        .mat_b_addr_i   (mat_b_addr_i),
        .mat_c_addr_i   (mat_c_addr_i),
        .mat_k_i        (mat_k_i),
        .start_i        (start_i),
        .done_o         (done_o),
        .busy_o         (busy_o),
        .rd_req_o       (rd_req_o),
        .rd_req_valid_o (rd_req_valid_o),
        .rd_req_ready_i (rd_req_ready_i),
        .rd_rsp_i       (rd_rsp_i),
        .rd_rsp_valid_i (rd_rsp_valid_i),
        .rd_rsp_ready_o (rd_rsp_ready_o),
        .wr_req_o       (wr_req_o),
        .wr_req_valid_o (wr_req_valid_o),
        .wr_req_ready_i (wr_req_ready_i),
        .buf_a_we_o     (buf_a_we),
        .buf_b_we_o     (buf_b_we),
        .buf_widx_o     (buf_widx),
        .buf_wdata_o    (buf_wdata),
        .mm_start_o     (mm_start),
        .mm_k_o         (mm_k),
        .mm_done_i      (mm_done),
        .acc_i          (acc)
    );

    // A columns
    tile_buffer #(.BUF_AW(BUF_AW)) u_buf_a (
        .clk     (clk),
        .we_i    (buf_a_we),
        .waddr_i (buf_widx),
        .wdata_i (buf_wdata),
        .raddr_i (mm_raddr),
        .rdata_o (a_col)
    );

    // B rows
    tile_buffer #(.BUF_AW(BUF_AW)) u_buf_b (
        .clk     (clk),
        .we_i    (buf_b_we),
        .waddr_i (buf_widx),
        .wdata_i (buf_wdata),
        .raddr_i (mm_raddr),
        .rdata_o (b_row)
    );

    mm_engine #(.BUF_AW(BUF_AW)) u_mm (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mm_start),
        .k_i     (mm_k),
        .done_o  (mm_done),
        .raddr_o (mm_raddr),
        .a_col_i (a_col),
        .b_row_i (b_row),
        .acc_o   (acc)
    );

endmodule

/* testbench/tb_mem_model.sv */
/*
 * behavioral memory for the gemm testbench
 * random ready stalls, in-order read responses after a random latency,
 * capture of the C write-back
 */

`timescale 1ns/1ns

module tb_mem_model #(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] SEED      = 32'h2bf8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_en_i,
    input  gemm_pkg::mem_rd_req_t rd_req_i,
    input  logic                  rd_req_valid_i,
    output logic                  rd_req_ready_o,
    output gemm_pkg::mem_rd_rsp_t rd_rsp_o,
    output logic                  rd_rsp_valid_o,
    input  logic                  rd_rsp_ready_i,
    input  gemm_pkg::mem_wr_req_t wr_req_i,
    input  logic                  wr_req_valid_i,
    output logic                  wr_req_ready_o
);
    import gemm_pkg::*;

    // read only from here, loaded by the testbench
    logic [31:0] mem [MEM_WORDS];
    // C words as written by the DUT
    logic [31:0] wr_cap [MEM_WORDS];
    int          wr_cnt;

    // accepted read waiting for its latency
    typedef struct packed {
        logic [31:0] due;
        mem_rd_rsp_t rsp;
    } pend_t;

    pend_t       pend_q [$];
    pend_t       entry;
    int          seed;
    int          cycle;
    int          word;
    int          lat;
    logic        stall_q;

    initial begin
        seed           = SEED;
        cycle          = 0;
        wr_cnt         = 0;
        stall_q        = 1'b0;
        rd_req_ready_o = 1'b0;
        rd_rsp_o       = '0;
        rd_rsp_valid_o = 1'b0;
        wr_req_ready_o = 1'b0;
        forever begin
            @(negedge clk);
            stall_q = stall_en_i;
            // handshakes seen here complete at the next rising edge
            if (rst_n) begin
                if (rd_rsp_valid_o && rd_rsp_ready_i) begin
                    void'(pend_q.pop_front());
                end
                if (rd_req_valid_i && rd_req_ready_o) begin
                    word          = int'(rd_req_i.addr >> 2) % MEM_WORDS;
                    lat           = stall_q ? 1 + ($random(seed) & 3) : 1;
                    entry.due     = 32'(cycle + lat);
                    entry.rsp.data = mem[word];
                    entry.rsp.id  = rd_req_i.id;
                    pend_q.push_back(entry);
                end
                if (wr_req_valid_i && wr_req_ready_o) begin
                    word         = int'(wr_req_i.addr >> 2) % MEM_WORDS;
                    wr_cap[word] = wr_req_i.data;
                    wr_cnt++;
                end
            end
            @(posedge clk);
            #10;
            cycle++;
            if (!rst_n) begin
                rd_req_ready_o = 1'b0;
                wr_req_ready_o = 1'b0;
                rd_rsp_valid_o = 1'b0;
            end else begin
                // about one stall in four
                rd_req_ready_o = !stall_q || (($random(seed) & 3) != 0);
                wr_req_ready_o = !stall_q || (($random(seed) & 3) != 0);
                // oldest read goes out once its latency is over
                if (pend_q.size() > 0 && int'(pend_q[0].due) <= cycle) begin
                    rd_rsp_o       = pend_q[0].rsp;
                    rd_rsp_valid_o = 1'b1;
                end else begin
                    rd_rsp_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* testbench/tb_gemm_top.sv */
/*
 * testbench for gemm_top with a behavioral memory
 * clock, reset, job stimulus, reference model for C, compare process, watchdog
 */

`timescale 1ns/1ns

module tb_gemm_top;
    import gemm_pkg::*;

    localparam int          BUF_AW     = 6;
    localparam int          K_W        = BUF_AW + 1;
    localparam int          MAX_K      = 2**BUF_AW;
    localparam int          NUM_RUNS   = 20;
    localparam int          CLK_PERIOD = 100;
    localparam int          DRIVE_DLY  = 10;
    localparam int          MEM_WORDS  = 1024;
    localparam logic [31:0] SEED       = 32'h2bf8;
    // 2K reads plus 16 writes per run, 8 cycles of stall margin per beat
    localparam int WATCHDOG_NS = NUM_RUNS * (2 * MAX_K + 16) * 8 * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] mat_a_addr;
    logic [31:0] mat_b_addr;
    logic [31:0] mat_c_addr;
    logic [K_W-1:0] mat_k;
    logic        start;
    logic        done;
    logic        busy;
    mem_rd_req_t rd_req;
    logic        rd_req_valid;
    logic        rd_req_ready;
    mem_rd_rsp_t rd_rsp;
    logic        rd_rsp_valid;
    logic        rd_rsp_ready;
    mem_wr_req_t wr_req;
    logic        wr_req_valid;
    logic        wr_req_ready;
    logic        stall_en;

    int          seed;
    int          k_cur;
    logic [31:0] exp_c [16];
    logic [31:0] rd_exp_addr;
    // owned by the compare process, cleared at each done pulse
    int          wr_n;
    int          rd_n;
    int          done_cnt;
    bit          rd_seen [2][MAX_K];

    gemm_top #(.BUF_AW(BUF_AW)) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .mat_a_addr_i   (mat_a_addr),
        .mat_b_addr_i   (mat_b_addr),
        .mat_c_addr_i   (mat_c_addr),
        .mat_k_i        (mat_k),
        .start_i        (start),
        .done_o         (done),
        .busy_o         (busy),
        .rd_req_o       (rd_req),
        .rd_req_valid_o (rd_req_valid),
        .rd_req_ready_i (rd_req_ready),
        .rd_rsp_i       (rd_rsp),
        .rd_rsp_valid_i (rd_rsp_valid),
        .rd_rsp_ready_o (rd_rsp_ready),
        .wr_req_o       (wr_req),
        .wr_req_valid_o (wr_req_valid),
        .wr_req_ready_i (wr_req_ready)
    );

    tb_mem_model #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) u_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_en_i     (stall_en),
        .rd_req_i       (rd_req),
        .rd_req_valid_i (rd_req_valid),
        .rd_req_ready_o (rd_req_ready),
        .rd_rsp_o       (rd_rsp),
        .rd_rsp_valid_o (rd_rsp_valid),
        .rd_rsp_ready_i (rd_rsp_ready),
        .wr_req_i       (wr_req),
        .wr_req_valid_i (wr_req_valid),
        .wr_req_ready_o (wr_req_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(input string what);
        $display("[FAIL] %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
            $display("TEST FAILED");
            $fatal(1, "stopped on first error");
        end
    endtask

    // C(i,j) = sum over k of A(i,k) * B(k,j), taken from the memory image
    function automatic logic [31:0] expected_c(input int i, input int j, input int k_len);
        int                sum;
        logic [31:0]       a_word;
        logic [31:0]       b_word;
        logic signed [7:0] a_el;
        logic signed [7:0] b_el;
        sum = 0;
        for (int kk = 0; kk < k_len; kk++) begin
            // beat k of A is column k, beat k of B is row k
            a_word = u_mem.mem[int'(mat_a_addr >> 2) + kk];
            b_word = u_mem.mem[int'(mat_b_addr >> 2) + kk];
            a_el   = a_word[8*i +: 8];
            b_el   = b_word[8*j +: 8];
            sum    = sum + int'(a_el) * int'(b_el);
        end
        return sum;
    endfunction

    // random signed operands, or every element at -128
    task automatic fill_operands(input int k_len, input bit extreme);
        for (int kk = 0; kk < k_len; kk++) begin
            u_mem.mem[int'(mat_a_addr >> 2) + kk] = extreme ? 32'h8080_8080 : $random(seed);
            u_mem.mem[int'(mat_b_addr >> 2) + kk] = extreme ? 32'h8080_8080 : $random(seed);
        end
    endtask

    // one job: load operands, start, stay busy until done, then idle checks
    task automatic run_job(input int run, input int k_len, input bit extreme);
        int n;
        mat_a_addr = 32'(4 * run);
        mat_b_addr = 32'(32'h400 + 4 * run);
        mat_c_addr = 32'(32'h800 + 64 * run);
        mat_k      = K_W'(k_len);
        k_cur      = k_len;
        fill_operands(k_len, extreme);
        for (int e = 0; e < 16; e++) begin
            exp_c[e] = expected_c(e / 4, e % 4, k_len);
        end
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        n     = 0;
        // a second start lands in the middle of the job
        while (!done) begin
            check_value("busy_o", 32'd1, 32'(busy));
            start = (n == 3);
            n++;
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_value("busy_o", 32'd0, 32'(busy));
        check_value("write count", 32'd16, 32'(wr_n));
        check_value("read count", 32'(2 * k_len), 32'(rd_n));
        for (int e = 0; e < 16; e++) begin
            check_value("captured C word", exp_c[e],
                        u_mem.wr_cap[int'(mat_c_addr >> 2) + e]);
        end
        repeat (3) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_value("done_o", 32'd0, 32'(done));
            check_value("busy_o", 32'd0, 32'(busy));
        end
        check_value("done pulses", 32'(run + 1), 32'(done_cnt));
    endtask

    // compare process
    // at the falling edge the handshakes of the next rising edge are settled
    always @(negedge clk) begin
        if (rst_n) begin
            // responses are never held off
            if (rd_rsp_valid) begin
                check_value("rd_rsp_ready_o", 32'd1, 32'(rd_rsp_ready));
            end
            if (rd_req_valid && rd_req_ready) begin
                if (int'(rd_req.id.idx) >= k_cur) begin
                    report_error("read request index lies beyond K");
                end
                rd_exp_addr = (rd_req.id.sel ? mat_b_addr : mat_a_addr)
                              + (32'(rd_req.id.idx) << 2);
                check_value("rd_req_o.addr", rd_exp_addr, rd_req.addr);
                if (rd_seen[rd_req.id.sel][rd_req.id.idx]) begin
                    report_error("the same read request was issued twice");
                end
                rd_seen[rd_req.id.sel][rd_req.id.idx] = 1'b1;
                rd_n++;
            end
            if (wr_req_valid && wr_req_ready) begin
                if (wr_n >= 16) begin
                    report_error("more than 16 result writes in one job");
                end
                // row-major, one word per result
                check_value("wr_req_o.addr", mat_c_addr + 32'(wr_n * 4), wr_req.addr);
                check_value("wr_req_o.data", exp_c[wr_n], wr_req.data);
                wr_n++;
            end
            if (done) begin
                done_cnt++;
                wr_n = 0;
                rd_n = 0;
                for (int s = 0; s < 2; s++) begin
                    for (int i = 0; i < MAX_K; i++) begin
                        rd_seen[s][i] = 1'b0;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("[FAIL] %0t ns: watchdog expired, the DMA did not finish all jobs", $time);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int k;
        bit extreme;
        seed       = SEED;
        rst_n      = 1'b0;
        start      = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        mat_k      = '0;
        stall_en   = 1'b0;
        k_cur      = 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            u_mem.mem[w] = $random(seed);
        end
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        // quiet after reset, and a start with K of zero is dropped
        start = 1'b1;
        repeat (3) begin
            check_value("done_o", 32'd0, 32'(done));
            check_value("busy_o", 32'd0, 32'(busy));
            check_value("rd_req_valid_o", 32'd0, 32'(rd_req_valid));
            check_value("wr_req_valid_o", 32'd0, 32'(wr_req_valid));
            @(posedge clk);
            #DRIVE_DLY;
            start = 1'b0;
        end
        for (int run = 0; run < NUM_RUNS; run++) begin
            extreme = (run == NUM_RUNS - 1);
            if (extreme) begin
                k = MAX_K;
            end else if (run == 1) begin
                k = 1;
            end else begin
                k = 1 + int'($unsigned($random(seed)) % MAX_K);
            end
            // first job without memory stalls
            stall_en = (run != 0);
            run_job(run, k, extreme);
        end
        check_value("captured write count", 32'(16 * NUM_RUNS), 32'(u_mem.wr_cnt));
        $display("TEST OK");
        $finish;
    end

endmodule

/* sim.f */
hw/gemm_pkg.sv
hw/tile_buffer.sv
hw/dma_engine.sv
hw/mm_engine.sv
hw/gemm_top.sv
testbench/tb_mem_model.sv
testbench/tb_gemm_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gemm_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
